// File: soc_pkg.sv
`default_nettype none

package soc_pkg;

  // --------------------------------------------------------------------
  // bus widths
  // --------------------------------------------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // --------------------------------------------------------------------
  // address map
  // --------------------------------------------------------------------
  // debug ram, 64 words
  localparam logic [ADDR_W-1:0] DEBUG_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] DEBUG_LEN  = 32'h0000_0100;
  // clint style timer block
  localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [ADDR_W-1:0] CLINT_LEN  = 32'h0000_C000;
  // off-chip memory port
  localparam logic [ADDR_W-1:0] EXT_BASE   = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] EXT_LEN    = 32'h1000_0000;

  // clint register offsets from CLINT_BASE, high words sit 4 bytes up
  localparam logic [15:0] CLINT_MSIP_OFS     = 16'h0000;
  localparam logic [15:0] CLINT_MTIMECMP_OFS = 16'h4000;
  localparam logic [15:0] CLINT_MTIME_OFS    = 16'hBFF8;

  // debug requests refused for this many cycles after reset
  localparam int unsigned DMI_DEL_CYCLES = 40;

  // --------------------------------------------------------------------
  // apb bus
  // --------------------------------------------------------------------
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic              pready;
    logic              pslverr;
    logic [DATA_W-1:0] prdata;
  } apb_rsp_t;

  // --------------------------------------------------------------------
  // debug module interface
  // --------------------------------------------------------------------
  typedef enum logic [1:0] {
    DMI_NOP   = 2'h0,
    DMI_READ  = 2'h1,
    DMI_WRITE = 2'h2
  } dmi_op_e;

  typedef enum logic [1:0] {
    DMI_OK     = 2'h0,
    DMI_FAILED = 2'h2
  } dmi_status_e;

  typedef struct packed {
    dmi_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } dmi_req_t;

  typedef struct packed {
    dmi_status_e       status;
    logic [DATA_W-1:0] data;
  } dmi_rsp_t;

  // decoder target select
  typedef enum logic [1:0] {
    SLV_DEBUG,
    SLV_CLINT,
    SLV_EXT,
    SLV_NONE
  } slave_e;

endpackage

`default_nettype wire

// File: bus_arbiter.sv
`default_nettype none

module bus_arbiter (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  // core side master
  input  wire soc_pkg::apb_req_t core_req_i,
  output soc_pkg::apb_rsp_t      core_rsp_o,
  // debug bridge master
  input  wire soc_pkg::apb_req_t dbg_req_i,
  output soc_pkg::apb_rsp_t      dbg_rsp_o,
  // shared system bus
  output soc_pkg::apb_req_t      bus_req_o,
  input  wire soc_pkg::apb_rsp_t bus_rsp_i
);

  // bus held by one master from its setup until its completing access
  logic lock_q;
  // set while the debug master owns the locked bus
  logic owner_dbg_q;
  // set when the last completed transfer came from the debug master
  logic last_dbg_q;
  logic gnt_dbg;
  soc_pkg::apb_req_t sel_req;

  // --------------------------------------------------------------------
  // grant
  // --------------------------------------------------------------------
  always_comb begin
    if (lock_q) begin
      gnt_dbg = owner_dbg_q;
    end else if (core_req_i.psel && dbg_req_i.psel) begin
      // contention, less recently served master wins
      gnt_dbg = ~last_dbg_q;
    end else begin
      gnt_dbg = dbg_req_i.psel;
    end
  end

  // forward the owner only
  // penable held low on a fresh grant, so the bus always sees a setup
  // cycle even if the waiting master already moved to its access phase
  always_comb begin
    sel_req           = gnt_dbg ? dbg_req_i : core_req_i;
    bus_req_o         = sel_req;
    bus_req_o.penable = sel_req.penable & lock_q;
  end

  // response goes back to the owner, the other master sees pready low
  always_comb begin
    core_rsp_o = '0;
    dbg_rsp_o  = '0;
    if (gnt_dbg) begin
      dbg_rsp_o = bus_rsp_i;
    end else begin
      core_rsp_o = bus_rsp_i;
    end
  end

  // --------------------------------------------------------------------
  // lock and fairness state
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q      <= 1'b0;
      owner_dbg_q <= 1'b0;
      // core goes first after reset
      last_dbg_q  <= 1'b1;
    end else if (bus_req_o.psel) begin
      if (bus_req_o.penable && bus_rsp_i.pready) begin
        // completing access, release the bus
        lock_q     <= 1'b0;
        last_dbg_q <= gnt_dbg;
      end else begin
        lock_q      <= 1'b1;
        owner_dbg_q <= gnt_dbg;
      end
    end else begin
      lock_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: addr_decoder.sv
`default_nettype none

module addr_decoder (
  // from the arbiter
  input  wire soc_pkg::apb_req_t bus_req_i,
  output soc_pkg::apb_rsp_t      bus_rsp_o,
  // target requests
  output soc_pkg::apb_req_t      ram_req_o,
  output soc_pkg::apb_req_t      clint_req_o,
  output soc_pkg::apb_req_t      ext_req_o,
  // target responses
  input  wire soc_pkg::apb_rsp_t ram_rsp_i,
  input  wire soc_pkg::apb_rsp_t clint_rsp_i,
  input  wire soc_pkg::apb_rsp_t ext_rsp_i
);

  soc_pkg::slave_e sel;
  logic [soc_pkg::ADDR_W-1:0] addr;
  logic acc;

  assign addr = bus_req_i.paddr;
  assign acc  = bus_req_i.psel & bus_req_i.penable;

  // --------------------------------------------------------------------
  // region match
  // --------------------------------------------------------------------
  // offset from base below length, wraps for addresses under the base
  always_comb begin
    if ((addr - soc_pkg::DEBUG_BASE) < soc_pkg::DEBUG_LEN) begin
      sel = soc_pkg::SLV_DEBUG;
    end else if ((addr - soc_pkg::CLINT_BASE) < soc_pkg::CLINT_LEN) begin
      sel = soc_pkg::SLV_CLINT;
    end else if ((addr - soc_pkg::EXT_BASE) < soc_pkg::EXT_LEN) begin
      sel = soc_pkg::SLV_EXT;
    end else begin
      sel = soc_pkg::SLV_NONE;
    end
  end

  // shared request fields, psel only to the chosen target
  always_comb begin
    ram_req_o        = bus_req_i;
    clint_req_o      = bus_req_i;
    ext_req_o        = bus_req_i;
    ram_req_o.psel   = bus_req_i.psel && (sel == soc_pkg::SLV_DEBUG);
    clint_req_o.psel = bus_req_i.psel && (sel == soc_pkg::SLV_CLINT);
    ext_req_o.psel   = bus_req_i.psel && (sel == soc_pkg::SLV_EXT);
  end

  // --------------------------------------------------------------------
  // response mux
  // --------------------------------------------------------------------
  always_comb begin
    case (sel)
      soc_pkg::SLV_DEBUG: bus_rsp_o = ram_rsp_i;
      soc_pkg::SLV_CLINT: bus_rsp_o = clint_rsp_i;
      soc_pkg::SLV_EXT:   bus_rsp_o = ext_rsp_i;
      default: begin
        // unmapped, error on the first access cycle
        bus_rsp_o.pready  = acc;
        bus_rsp_o.pslverr = acc;
        bus_rsp_o.prdata  = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: debug_ram.sv
`default_nettype none

module debug_ram (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire soc_pkg::apb_req_t req_i,
  output soc_pkg::apb_rsp_t      rsp_o
);

  logic [soc_pkg::DATA_W-1:0] mem_q [64];
  logic [soc_pkg::DATA_W-1:0] rdata_q;
  logic [5:0] idx;
  // setup seen last cycle
  logic setup_q;

  // word index inside the 256 byte region
  assign idx = req_i.paddr[7:2];

  // synchronous array, read launched in the setup cycle
  always_ff @(posedge clk_i) begin
    if (req_i.psel && req_i.penable && req_i.pwrite) begin
      mem_q[idx] <= req_i.pwdata;
    end
    if (req_i.psel && !req_i.penable) begin
      rdata_q <= mem_q[idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= req_i.psel & ~req_i.penable;
    end
  end

  // zero wait states, never errors
  assign rsp_o.pready  = setup_q & req_i.psel & req_i.penable;
  assign rsp_o.pslverr = 1'b0;
  assign rsp_o.prdata  = rdata_q;

endmodule

`default_nettype wire

// File: clint_timer.sv
`default_nettype none

module clint_timer (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              rtc_i,
  input  wire soc_pkg::apb_req_t req_i,
  output soc_pkg::apb_rsp_t      rsp_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);

  // two sync flops, then one more for edge detect
  logic [2:0]  rtc_q;
  logic        rtc_tick;
  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        msip_q;
  logic        irq_q;
  logic [15:0] ofs;
  logic        acc;
  logic        wr;
  logic [soc_pkg::DATA_W-1:0] rdata;

  assign ofs = 16'(req_i.paddr - soc_pkg::CLINT_BASE);
  assign acc = req_i.psel & req_i.penable;
  assign wr  = acc & req_i.pwrite;

  // --------------------------------------------------------------------
  // rtc synchronizer
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q <= '0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
    end
  end

  // rising edge after sync
  assign rtc_tick = rtc_q[1] & ~rtc_q[2];

  // --------------------------------------------------------------------
  // registers
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      // software write wins over the tick
      if (wr && ofs == soc_pkg::CLINT_MTIME_OFS) begin
        mtime_q[31:0] <= req_i.pwdata;
      end else if (wr && ofs == soc_pkg::CLINT_MTIME_OFS + 16'h4) begin
        mtime_q[63:32] <= req_i.pwdata;
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr && ofs == soc_pkg::CLINT_MTIMECMP_OFS) begin
        mtimecmp_q[31:0] <= req_i.pwdata;
      end
      if (wr && ofs == soc_pkg::CLINT_MTIMECMP_OFS + 16'h4) begin
        mtimecmp_q[63:32] <= req_i.pwdata;
      end
      if (wr && ofs == soc_pkg::CLINT_MSIP_OFS) begin
        msip_q <= req_i.pwdata[0];
      end
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // read mux, unused offsets give zero
  always_comb begin
    rdata = '0;
    case (ofs)
      soc_pkg::CLINT_MSIP_OFS:             rdata[0] = msip_q;
      soc_pkg::CLINT_MTIMECMP_OFS:         rdata = mtimecmp_q[31:0];
      soc_pkg::CLINT_MTIMECMP_OFS + 16'h4: rdata = mtimecmp_q[63:32];
      soc_pkg::CLINT_MTIME_OFS:            rdata = mtime_q[31:0];
      soc_pkg::CLINT_MTIME_OFS + 16'h4:    rdata = mtime_q[63:32];
      default:                             rdata = '0;
    endcase
  end

  assign rsp_o.pready  = acc;
  assign rsp_o.pslverr = 1'b0;
  assign rsp_o.prdata  = rdata;

  assign timer_irq_o = irq_q;
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

// File: dmi_bridge.sv
`default_nettype none

module dmi_bridge (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  // debug request channel
  input  wire soc_pkg::dmi_req_t dmi_req_i,
  input  wire logic              dmi_req_valid_i,
  output logic                   dmi_req_ready_o,
  // debug response channel
  output soc_pkg::dmi_rsp_t      dmi_rsp_o,
  output logic                   dmi_rsp_valid_o,
  input  wire logic              dmi_rsp_ready_i,
  // apb master side
  output soc_pkg::apb_req_t      bus_req_o,
  input  wire soc_pkg::apb_rsp_t bus_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_RESP
  } state_e;

  state_e            state_q;
  int unsigned       del_cnt_q;
  soc_pkg::dmi_req_t req_q;
  soc_pkg::dmi_rsp_t rsp_q;
  logic              accept;
  logic              done;

  // --------------------------------------------------------------------
  // startup hold-off
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= soc_pkg::DMI_DEL_CYCLES;
    end else if (del_cnt_q != 0) begin
      del_cnt_q <= del_cnt_q - 1;
    end
  end

  assign dmi_req_ready_o = (state_q == ST_IDLE) && (del_cnt_q == 0);
  assign accept          = dmi_req_valid_i & dmi_req_ready_o;
  assign done            = (state_q == ST_ACCESS) & bus_rsp_i.pready;

  // --------------------------------------------------------------------
  // fsm
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // nop and unknown ops skip the bus
          if (accept) begin
            if (dmi_req_i.op inside {soc_pkg::DMI_READ, soc_pkg::DMI_WRITE}) begin
              state_q <= ST_SETUP;
            end else begin
              state_q <= ST_RESP;
            end
          end
        end
        ST_SETUP:  state_q <= ST_ACCESS;
        ST_ACCESS: if (done) state_q <= ST_RESP;
        ST_RESP:   if (dmi_rsp_ready_i) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // captured request and response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q        <= dmi_req_i;
      rsp_q.status <= soc_pkg::DMI_OK;
      rsp_q.data   <= '0;
    end else if (done) begin
      rsp_q.status <= bus_rsp_i.pslverr ? soc_pkg::DMI_FAILED : soc_pkg::DMI_OK;
      rsp_q.data   <= (req_q.op == soc_pkg::DMI_WRITE) ? '0 : bus_rsp_i.prdata;
    end
  end

  // apb request straight from the state
  always_comb begin
    bus_req_o.psel    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
    bus_req_o.penable = (state_q == ST_ACCESS);
    bus_req_o.pwrite  = (req_q.op == soc_pkg::DMI_WRITE);
    bus_req_o.paddr   = req_q.addr;
    bus_req_o.pwdata  = req_q.data;
  end

  assign dmi_rsp_valid_o = (state_q == ST_RESP);
  assign dmi_rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: soc_harness.sv
`default_nettype none

module soc_harness (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              rtc_i,
  // core side master port
  input  wire soc_pkg::apb_req_t core_req_i,
  output soc_pkg::apb_rsp_t      core_rsp_o,
  // debug module interface
  input  wire soc_pkg::dmi_req_t dmi_req_i,
  input  wire logic              dmi_req_valid_i,
  output logic                   dmi_req_ready_o,
  output soc_pkg::dmi_rsp_t      dmi_rsp_o,
  output logic                   dmi_rsp_valid_o,
  input  wire logic              dmi_rsp_ready_i,
  // off-chip memory port
  output soc_pkg::apb_req_t      ext_req_o,
  input  wire soc_pkg::apb_rsp_t ext_rsp_i,
  // interrupts
  output logic                   timer_irq_o,
  output logic                   ipi_o
);

  // debug master to arbiter
  soc_pkg::apb_req_t dbg_req;
  soc_pkg::apb_rsp_t dbg_rsp;
  // arbiter to decoder
  soc_pkg::apb_req_t bus_req;
  soc_pkg::apb_rsp_t bus_rsp;
  // decoder to targets
  soc_pkg::apb_req_t ram_req;
  soc_pkg::apb_rsp_t ram_rsp;
  soc_pkg::apb_req_t clint_req;
  soc_pkg::apb_rsp_t clint_rsp;

  // --------------------------------------------------------------------
  // masters
  // --------------------------------------------------------------------
  dmi_bridge i_dmi_bridge (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .dmi_req_i       ( dmi_req_i       ),
    .dmi_req_valid_i ( dmi_req_valid_i ),
    .dmi_req_ready_o ( dmi_req_ready_o ),
    .dmi_rsp_o       ( dmi_rsp_o       ),
    .dmi_rsp_valid_o ( dmi_rsp_valid_o ),
    .dmi_rsp_ready_i ( dmi_rsp_ready_i ),
    .bus_req_o       ( dbg_req         ),
    .bus_rsp_i       ( dbg_rsp         )
  );

  bus_arbiter i_bus_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .core_req_i ( core_req_i ),
    .core_rsp_o ( core_rsp_o ),
    .dbg_req_i  ( dbg_req    ),
    .dbg_rsp_o  ( dbg_rsp    ),
    .bus_req_o  ( bus_req    ),
    .bus_rsp_i  ( bus_rsp    )
  );

  // --------------------------------------------------------------------
  // decode and targets
  // --------------------------------------------------------------------
  addr_decoder i_addr_decoder (
    .bus_req_i   ( bus_req   ),
    .bus_rsp_o   ( bus_rsp   ),
    .ram_req_o   ( ram_req   ),
    .clint_req_o ( clint_req ),
    .ext_req_o   ( ext_req_o ),
    .ram_rsp_i   ( ram_rsp   ),
    .clint_rsp_i ( clint_rsp ),
    .ext_rsp_i   ( ext_rsp_i )
  );

  debug_ram i_debug_ram (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .req_i  ( ram_req ),
    .rsp_o  ( ram_rsp )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .rsp_o       ( clint_rsp   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

`default_nettype wire

// File: tb_soc_harness.sv
`default_nettype none

module tb_soc_harness;

  // --------------------------------------------------------------------
  // run length and watchdog budget
  // --------------------------------------------------------------------
  localparam int unsigned SEED   = 32'h0316b92e;
  localparam int          N_RAND = 32;
  localparam int          N_ERR  = 8;
  localparam int          N_DMI  = 20;
  localparam int          N_MIX  = 24;
  // mix steps write and maybe read before the final readback of every word
  localparam int XFER_COUNT = 2 * N_RAND + N_ERR + N_DMI + 4 * N_MIX
                              + (N_RAND + N_DMI + 2 * N_MIX) + 16;
  localparam int TIMEOUT_CYCLES = XFER_COUNT * 20 + soc_pkg::DMI_DEL_CYCLES + 500;

  // clint register addresses
  localparam logic [31:0] MSIP_ADDR     = soc_pkg::CLINT_BASE + 32'(soc_pkg::CLINT_MSIP_OFS);
  localparam logic [31:0] MTIMECMP_ADDR = soc_pkg::CLINT_BASE + 32'(soc_pkg::CLINT_MTIMECMP_OFS);
  localparam logic [31:0] MTIME_ADDR    = soc_pkg::CLINT_BASE + 32'(soc_pkg::CLINT_MTIME_OFS);

  logic clk = 1'b0;
  logic rst_n;
  logic rtc;
  soc_pkg::apb_req_t core_req;
  soc_pkg::apb_rsp_t core_rsp;
  soc_pkg::dmi_req_t dmi_req;
  logic              dmi_req_valid;
  logic              dmi_req_ready;
  soc_pkg::dmi_rsp_t dmi_rsp;
  logic              dmi_rsp_valid;
  logic              dmi_rsp_ready;
  soc_pkg::apb_req_t ext_req;
  soc_pkg::apb_rsp_t ext_rsp = '0;
  logic              timer_irq;
  logic              ipi;

  // expected contents and off-chip memory keyed by byte address
  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] ext_mem [logic [31:0]];
  logic [31:0] written_q [$];
  int ext_wait;
  int n_checks = 0;
  int n_errors = 0;

  soc_harness DUT (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .rtc_i           ( rtc           ),
    .core_req_i      ( core_req      ),
    .core_rsp_o      ( core_rsp      ),
    .dmi_req_i       ( dmi_req       ),
    .dmi_req_valid_i ( dmi_req_valid ),
    .dmi_req_ready_o ( dmi_req_ready ),
    .dmi_rsp_o       ( dmi_rsp       ),
    .dmi_rsp_valid_o ( dmi_rsp_valid ),
    .dmi_rsp_ready_i ( dmi_rsp_ready ),
    .ext_req_o       ( ext_req       ),
    .ext_rsp_i       ( ext_rsp       ),
    .timer_irq_o     ( timer_irq     ),
    .ipi_o           ( ipi           )
  );

  always #10 clk = ~clk;

  // --------------------------------------------------------------------
  // off-chip memory with 0 to 3 wait cycles per access
  // --------------------------------------------------------------------
  function automatic logic [31:0] ext_read(input logic [31:0] addr);
    if (ext_mem.exists(addr)) begin
      return ext_mem[addr];
    end
    // unwritten words give a pattern of the whole address
    return addr ^ 32'hc3a5_5a3c;
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      ext_rsp <= '0;
    end else if (ext_req.psel && ext_req.penable && ext_rsp.pready) begin
      // completing access
      if (ext_req.pwrite) begin
        ext_mem[ext_req.paddr] = ext_req.pwdata;
      end
      ext_rsp <= '0;
    end else if (ext_req.psel) begin
      // wait count picked in setup and counted down over access cycles
      if (!ext_req.penable) begin
        ext_wait = $urandom_range(3);
      end else begin
        ext_wait = ext_wait - 1;
      end
      if (ext_wait <= 0) begin
        ext_rsp.pready <= 1'b1;
        ext_rsp.prdata <= ext_read(ext_req.paddr);
      end
    end
  end

  // --------------------------------------------------------------------
  // checks and model
  // --------------------------------------------------------------------
  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("error at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    if (n_errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, n_errors - err_start);
    end
  endtask

  task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
    if (!ref_mem.exists(addr)) begin
      written_q.push_back(addr);
    end
    ref_mem[addr] = data;
  endtask

  // debug ram or off-chip word in the half of each region given by half
  function automatic logic [31:0] rand_mapped_addr(input logic half);
    logic [31:0] a;
    if ($urandom_range(1) == 0) begin
      a = {24'h0, half, 5'($urandom_range(31)), 2'b00};
    end else begin
      a = soc_pkg::EXT_BASE | {20'h0, 9'($urandom_range(511)), half, 2'b00};
    end
    return a;
  endfunction

  function automatic logic [31:0] rand_unmapped_addr();
    logic [31:0] a;
    case ($urandom_range(2))
      0:       a = 32'h1000_0000 | {4'h0, 26'($urandom), 2'b00};
      // just past the clint block
      1:       a = 32'h0200_C000 + {24'h0, 6'($urandom), 2'b00};
      default: a = 32'h9000_0000 | {4'h0, 26'($urandom), 2'b00};
    endcase
    return a;
  endfunction

  // --------------------------------------------------------------------
  // bus drivers
  // --------------------------------------------------------------------
  task automatic core_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
    @(posedge clk);
    core_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    core_req.penable <= 1'b1;
    // may be held off by the debug master
    @(negedge clk);
    while (!core_rsp.pready) begin
      @(negedge clk);
    end
    rdata = core_rsp.prdata;
    err   = core_rsp.pslverr;
    @(posedge clk);
    core_req <= '0;
  endtask

  task automatic core_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    core_xfer(1'b1, addr, data, rd, err);
    check_word("core write error flag", 32'(err), 32'd0);
  endtask

  task automatic core_read(input logic [31:0] addr, output logic [31:0] data);
    logic err;
    core_xfer(1'b0, addr, 32'd0, data, err);
    check_word("core read error flag", 32'(err), 32'd0);
  endtask

  task automatic dmi_xfer(input soc_pkg::dmi_op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, output soc_pkg::dmi_status_e status,
                          output logic [31:0] rdata);
    int hold;
    hold = $urandom_range(2);
    @(posedge clk);
    dmi_req       <= '{op: op, addr: addr, data: wdata};
    dmi_req_valid <= 1'b1;
    @(negedge clk);
    while (!dmi_req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    dmi_req_valid <= 1'b0;
    @(negedge clk);
    while (!dmi_rsp_valid) begin
      @(negedge clk);
    end
    status = dmi_rsp.status;
    rdata  = dmi_rsp.data;
    // some back-pressure on the response
    repeat (hold) @(posedge clk);
    @(posedge clk);
    dmi_rsp_ready <= 1'b1;
    @(posedge clk);
    dmi_rsp_ready <= 1'b0;
  endtask

  // one rtc rising edge every 7 cycles
  task automatic rtc_edge();
    @(posedge clk);
    rtc <= 1'b1;
    repeat (3) @(posedge clk);
    rtc <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic mixed_stream(input logic use_dmi);
    logic [31:0] own_q [$];
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    soc_pkg::dmi_status_e st;
    for (int k = 0; k < N_MIX; k++) begin
      addr = rand_mapped_addr(use_dmi);
      data = $urandom;
      if (use_dmi) begin
        dmi_xfer(soc_pkg::DMI_WRITE, addr, data, st, rd);
        check_word("debug write status", 32'(st), 32'(soc_pkg::DMI_OK));
      end else begin
        core_write(addr, data);
      end
      model_write(addr, data);
      own_q.push_back(addr);
      if ($urandom_range(1) == 1) begin
        addr = own_q[$urandom_range(own_q.size() - 1)];
        if (use_dmi) begin
          dmi_xfer(soc_pkg::DMI_READ, addr, 32'd0, st, rd);
          check_word("debug read status", 32'(st), 32'(soc_pkg::DMI_OK));
        end else begin
          core_read(addr, rd);
        end
        check_word("read during mix", rd, ref_mem[addr]);
      end
    end
  endtask

  // --------------------------------------------------------------------
  // watchdog
  // --------------------------------------------------------------------
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  // --------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------
  initial begin
    int                   start;
    int                   n_edges;
    logic [31:0]          addr;
    logic [31:0]          data;
    logic [31:0]          rd;
    logic                 err;
    soc_pkg::dmi_status_e st;
    soc_pkg::dmi_op_e     op;
    void'($urandom(SEED));
    rst_n         = 1'b0;
    rtc           = 1'b0;
    core_req      = '0;
    dmi_req       = '0;
    dmi_req_valid = 1'b0;
    dmi_rsp_ready = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // reset values and the debug hold-off window
    start = n_errors;
    @(negedge clk);
    check_word("core pready after reset", 32'(core_rsp.pready), 32'd0);
    check_word("ext psel after reset", 32'(ext_req.psel), 32'd0);
    check_word("dmi rsp valid after reset", 32'(dmi_rsp_valid), 32'd0);
    check_word("timer irq after reset", 32'(timer_irq), 32'd0);
    check_word("ipi after reset", 32'(ipi), 32'd0);
    for (int k = 0; k < soc_pkg::DMI_DEL_CYCLES; k++) begin
      check_word("dmi ready during hold-off", 32'(dmi_req_ready), 32'd0);
      @(negedge clk);
    end
    report_test("reset and hold-off", start);

    start = n_errors;
    for (int k = 0; k < N_RAND; k++) begin
      addr = rand_mapped_addr(1'($urandom_range(1)));
      data = $urandom;
      core_write(addr, data);
      model_write(addr, data);
    end
    for (int k = 0; k < N_RAND; k++) begin
      addr = written_q[$urandom_range(written_q.size() - 1)];
      core_read(addr, rd);
      check_word("core read", rd, ref_mem[addr]);
    end
    report_test("core random write and read", start);

    start = n_errors;
    for (int k = 0; k < N_ERR; k++) begin
      core_xfer(1'($urandom_range(1)), rand_unmapped_addr(), $urandom, rd, err);
      check_word("unmapped error flag", 32'(err), 32'd1);
      check_word("unmapped read data", rd, 32'd0);
    end
    report_test("core unmapped", start);

    start = n_errors;
    for (int k = 0; k < N_DMI; k++) begin
      case ($urandom_range(3))
        0: begin
          dmi_xfer(soc_pkg::DMI_NOP, $urandom, $urandom, st, rd);
          check_word("nop status", 32'(st), 32'(soc_pkg::DMI_OK));
          check_word("nop data", rd, 32'd0);
        end
        1: begin
          addr = rand_mapped_addr(1'($urandom_range(1)));
          data = $urandom;
          dmi_xfer(soc_pkg::DMI_WRITE, addr, data, st, rd);
          check_word("debug write status", 32'(st), 32'(soc_pkg::DMI_OK));
          model_write(addr, data);
        end
        2: begin
          addr = written_q[$urandom_range(written_q.size() - 1)];
          dmi_xfer(soc_pkg::DMI_READ, addr, 32'd0, st, rd);
          check_word("debug read status", 32'(st), 32'(soc_pkg::DMI_OK));
          check_word("debug read", rd, ref_mem[addr]);
        end
        default: begin
          if ($urandom_range(1) == 1) begin
            op = soc_pkg::DMI_WRITE;
          end else begin
            op = soc_pkg::DMI_READ;
          end
          dmi_xfer(op, rand_unmapped_addr(), $urandom, st, rd);
          check_word("unmapped debug status", 32'(st), 32'(soc_pkg::DMI_FAILED));
          check_word("unmapped debug data", rd, 32'd0);
        end
      endcase
    end
    report_test("debug access", start);

    // both masters at once in separate halves of the regions
    start = n_errors;
    fork
      mixed_stream(1'b0);
      mixed_stream(1'b1);
    join
    foreach (written_q[i]) begin
      core_read(written_q[i], rd);
      check_word("final contents", rd, ref_mem[written_q[i]]);
    end
    report_test("core and debug together", start);

    start = n_errors;
    n_edges = 3 + $urandom_range(5);
    // move mtime off zero so the clear below matters
    repeat (2) rtc_edge();
    core_write(MTIME_ADDR, 32'd0);
    core_write(MTIME_ADDR + 32'd4, 32'd0);
    repeat (n_edges) rtc_edge();
    repeat (4) @(posedge clk);
    core_read(MTIME_ADDR, rd);
    check_word("mtime low", rd, 32'(n_edges));
    core_read(MTIME_ADDR + 32'd4, rd);
    check_word("mtime high", rd, 32'd0);
    core_write(MTIMECMP_ADDR, 32'(n_edges + 2));
    core_write(MTIMECMP_ADDR + 32'd4, 32'd0);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_word("timer irq below compare", 32'(timer_irq), 32'd0);
    rtc_edge();
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_word("timer irq one edge short", 32'(timer_irq), 32'd0);
    rtc_edge();
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_word("timer irq at compare", 32'(timer_irq), 32'd1);
    core_write(MSIP_ADDR, 32'd1);
    @(negedge clk);
    check_word("ipi set", 32'(ipi), 32'd1);
    core_read(MSIP_ADDR, rd);
    check_word("msip readback", rd, 32'd1);
    core_write(MSIP_ADDR, 32'd0);
    @(negedge clk);
    check_word("ipi cleared", 32'(ipi), 32'd0);
    report_test("clint", start);

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
soc_pkg.sv
bus_arbiter.sv
addr_decoder.sv
debug_ram.sv
clint_timer.sv
dmi_bridge.sv
soc_harness.sv
tb_soc_harness.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_harness
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
